// ==== verification/pad_tests.txt ====
# kind: 1 map, 2 port 2 zero fill, 3 autofire, 4 hotkey; all fields hex
# per player: ds_b0 ds_b1 usb_btn usb_x usb_y serial_pad (p1 first, then p2)
# last two: expected p1 and p2 bytes (kind 3: p1 column = high cycles in window)
1 FF FF 00 0 0 00 FF FF 00 0 0 00 00 00
1 DF FF 00 0 0 00 7F FF 00 0 0 00 80 40
1 BF FF 00 0 0 00 EF FF 00 0 0 00 20 10
1 F7 FF 00 0 0 00 FE FF 00 0 0 00 08 04
1 FF BF 00 0 0 00 FF DF 00 0 0 00 02 01
1 F9 F0 00 0 0 00 FF FF A5 0 0 00 00 A5
1 FF FF 00 0 0 5A DF FF 01 0 0 08 5A 89
1 5A FF 00 0 0 00 00 9F 00 0 0 00 C4 FF
1 FF 7F 00 0 0 00 FF FF 00 0 1 00 02 02
1 FF EF 00 0 0 00 FF FF 01 1 0 00 01 01
1 DF FF 80 0 0 80 FE BF 02 0 0 04 80 06
1 AF FF 08 0 0 00 FF FF 00 0 0 FF 38 FF
2 FF FF 00 0 0 81 FF FF C3 0 0 00 81 C3
2 FF FF 00 0 0 00 00 00 00 0 0 00 00 FF
3 FF EF 00 0 0 00 FF FF 00 0 0 00 10 00
3 FF FF 00 1 0 00 FF FF 00 0 0 00 10 00
4 BE FF 00 0 0 00 FF FF 00 0 0 00 24 00
4 FF FF 24 0 0 00 7F FF 00 0 0 00 24 40
4 BF FF 00 0 0 04 FF FF 00 0 0 00 24 00

// ==== all.f ====
+incdir+design
design/pad_pkg.sv
design/nes_port_pkg.sv
design/pad_mapper.sv
design/joypad_shifter.sv
design/reset_supervisor.sv
design/pad_top.sv
verification/pad_properties.sv
verification/pad_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = pad_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/pad_tb.sv ====
// testbench for the controller path
// power-up reset hold, file-driven mapping and shift-out, zero fill,
// autofire and hotkey reset checks

`timescale 1ns/1ps
`default_nettype none

`include "pad_defines.svh"

module pad_tb;

    import pad_pkg::*;
    import nes_port_pkg::*;

    localparam logic [7:0] kind_map  = 8'h1;   // strobe, eight clocks on both ports
    localparam logic [7:0] kind_fill = 8'h2;   // port 2 alone, ten clocks
    localparam logic [7:0] kind_fire = 8'h3;   // autofire on port 1, strobe held
    localparam logic [7:0] kind_hot  = 8'h4;   // select + down core reset

    logic         clk;
    logic         sys_resetn;
    ds_byte_t     ds_b0_p1, ds_b1_p1, ds_b0_p2, ds_b1_p2;
    nes_buttons_t usb_btn_p1, serial_pad_p1, usb_btn_p2, serial_pad_p2;
    logic         usb_x_p1, usb_y_p1, usb_x_p2, usb_y_p2;
    logic         joypad_strobe;
    port_bits_t   joypad_clock;
    port_bits_t   joypad_data;
    logic         core_resetn;

    logic [7:0]   f [15];                   // kind, p1 sources, p2 sources, p1 and p2 bytes
    logic [15:0]  shifted_p1;               // serial bits, first one in bit 0
    logic [15:0]  shifted_p2;
    int           value_errors;
    int           other_errors;
    int           vectors;

    pad_top dut (
        .clk (clk), .sys_resetn (sys_resetn),
        .i_ds_b0_p1 (ds_b0_p1), .i_ds_b1_p1 (ds_b1_p1), .i_usb_btn_p1 (usb_btn_p1),
        .i_usb_x_p1 (usb_x_p1), .i_usb_y_p1 (usb_y_p1), .i_serial_pad_p1 (serial_pad_p1),
        .i_ds_b0_p2 (ds_b0_p2), .i_ds_b1_p2 (ds_b1_p2), .i_usb_btn_p2 (usb_btn_p2),
        .i_usb_x_p2 (usb_x_p2), .i_usb_y_p2 (usb_y_p2), .i_serial_pad_p2 (serial_pad_p2),
        .i_joypad_strobe (joypad_strobe), .i_joypad_clock (joypad_clock),
        .o_joypad_data (joypad_data), .o_core_resetn (core_resetn)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    //////////////////////////////
    // drive helpers
    //////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;                                 // inputs move just after the edge
    endtask

    task automatic drive_idle();
        ds_b0_p1 = 8'hff;                   // DualShock idle is all ones
        ds_b1_p1 = 8'hff;
        ds_b0_p2 = 8'hff;
        ds_b1_p2 = 8'hff;
        usb_btn_p1 = '0;
        usb_btn_p2 = '0;
        serial_pad_p1 = '0;
        serial_pad_p2 = '0;
        {usb_x_p1, usb_y_p1, usb_x_p2, usb_y_p2} = '0;
    endtask

    task automatic drive_vector();
        ds_b0_p1 = f[1];
        ds_b1_p1 = f[2];
        usb_btn_p1 = f[3];
        usb_x_p1 = f[4][0];
        usb_y_p1 = f[5][0];
        serial_pad_p1 = f[6];
        ds_b0_p2 = f[7];
        ds_b1_p2 = f[8];
        usb_btn_p2 = f[9];
        usb_x_p2 = f[10][0];
        usb_y_p2 = f[11][0];
        serial_pad_p2 = f[12];
    endtask

    // one cycle for the mapper register, then a single strobe cycle
    task automatic strobe_load();
        next_cycle();
        joypad_strobe = 1'b1;
        next_cycle();
        joypad_strobe = 1'b0;
    endtask

    task automatic shift_out(input port_bits_t mask, input int pulses);
        shifted_p1 = '0;
        shifted_p2 = '0;
        for (int i = 0; i < pulses; i++) begin
            shifted_p1 = shifted_p1 | (16'(joypad_data[0]) << i);
            shifted_p2 = shifted_p2 | (16'(joypad_data[1]) << i);
            joypad_clock = mask;
            next_cycle();
            joypad_clock = '0;              // falling edge shifts
            next_cycle();
        end
        shifted_p1 = shifted_p1 | (16'(joypad_data[0]) << pulses);
        shifted_p2 = shifted_p2 | (16'(joypad_data[1]) << pulses);
    endtask

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic check_port(input int port, input logic [15:0] got, input logic [7:0] exp);
        assert (got[7:0] == exp) else begin
            value_errors++;
            $display("ERR o_joypad_data[%0d] got 0x%02h expected 0x%02h", port, got[7:0], exp);
        end
        // zeros only after the eighth bit
        assert (got[15:8] == 8'h00) else begin
            value_errors++;
            $display("ERR o_joypad_data[%0d] fill got 0x%02h expected 0x00", port, got[15:8]);
        end
    endtask

    task automatic check_delay(input int got, input int exp);
        assert (got == exp) else begin
            value_errors++;
            $display("ERR o_core_resetn delay got 0x%0h expected 0x%0h", got, exp);
        end
    endtask

    task automatic count_until_reset(input logic level, input int limit, output int cycles);
        cycles = 0;
        while (core_resetn !== level && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        assert (core_resetn === level) else begin
            other_errors++;
            $display("timeout: o_core_resetn never reached %0b in %0d cycles", level, limit);
        end
    endtask

    task automatic run_autofire(input logic [7:0] exp_high);
        int waited;
        int high_cnt;
        waited = 0;
        high_cnt = 0;
        joypad_strobe = 1'b1;               // port 1 follows the mapped A bit
        while (joypad_data[0] !== 1'b1 && waited < 4 * `PAD_AUTOFIRE_HALF) begin
            next_cycle();
            waited++;
        end
        assert (joypad_data[0] === 1'b1) else begin
            other_errors++;
            $display("timeout: autofire never raised port 1 data");
        end
        for (int i = 0; i < 4 * `PAD_AUTOFIRE_HALF; i++) begin
            if (joypad_data[0] === 1'b1) high_cnt++;
            next_cycle();
        end
        assert (high_cnt == int'(exp_high)) else begin
            value_errors++;
            $display("ERR o_joypad_data[0] high cycles got 0x%0h expected 0x%0h",
                     high_cnt, exp_high);
        end
        drive_idle();
        waited = 0;
        while (joypad_data[0] !== 1'b0 && waited < 2) begin
            next_cycle();
            waited++;
        end
        assert (joypad_data[0] === 1'b0) else begin
            other_errors++;
            $display("autofire still high on port 1 two cycles after release");
        end
        joypad_strobe = 1'b0;
    endtask

    task automatic run_hotkey(input logic [7:0] exp_p1, input logic [7:0] exp_p2);
        int cycles;
        count_until_reset(1'b0, 8, cycles);
        check_delay(cycles, 2);             // mapper register, then reset register
        strobe_load();
        shift_out(2'b11, `PAD_BTN_W);
        check_port(0, shifted_p1, exp_p1);
        check_port(1, shifted_p2, exp_p2);
        drive_idle();
        count_until_reset(1'b1, 8, cycles);
        check_delay(cycles, 2);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int    fd;
        int    n;
        int    cycles;
        string line;
        value_errors = 0;
        other_errors = 0;
        vectors = 0;
        void'($urandom(52));
        sys_resetn = 1'b0;
        joypad_strobe = 1'b0;
        joypad_clock = '0;
        drive_idle();
        repeat (10) next_cycle();
        sys_resetn = 1'b1;

        // power-up hold, low for the hold length after release
        count_until_reset(1'b1, 2 * `PAD_RESET_HOLD, cycles);
        check_delay(cycles, `PAD_RESET_HOLD);

        fd = $fopen("verification/pad_tests.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open the test vector file");
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (n != 15) begin
                other_errors++;
                $display("test vector line has %0d fields instead of 15", n);
                continue;
            end
            vectors++;
            drive_vector();
            case (f[0])
                kind_map: begin
                    strobe_load();
                    shift_out(2'b11, `PAD_BTN_W);
                    check_port(0, shifted_p1, f[13]);
                    check_port(1, shifted_p2, f[14]);
                end
                kind_fill: begin
                    strobe_load();
                    shift_out(2'b10, 10);   // two clocks past the last bit
                    check_port(1, shifted_p2, f[14]);
                    assert (joypad_data[0] === f[13][0]) else begin
                        value_errors++;
                        $display("ERR o_joypad_data[0] got 0x%0h expected 0x%0h",
                                 joypad_data[0], f[13][0]);
                    end
                end
                kind_fire: run_autofire(f[13]);
                kind_hot:  run_hotkey(f[13], f[14]);
                default: begin
                    other_errors++;
                    $display("unknown test kind %0h in the vector file", f[0]);
                end
            endcase
            drive_idle();
            repeat ($urandom_range(3)) next_cycle();   // idle filler
        end
        if (fd != 0) $fclose(fd);
        if (vectors == 0) begin
            other_errors++;
            $display("no test vectors were run");
        end

        $display("errors: %0d value, %0d other, over %0d vectors",
                 value_errors, other_errors, vectors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/pad_properties.sv ====
// concurrent checks for the joypad ports and the core reset
// zero data after eight shifts without a strobe, core reset follows system reset

`timescale 1ns/1ps
`default_nettype none

`include "pad_defines.svh"

module pad_properties #(
    parameter bit check_shift = 1'b1    // 1 on the shifter, 0 on the supervisor
) (
    input wire                         clk,
    input wire                         sys_resetn,
    input wire                         i_strobe,
    input nes_port_pkg::port_bits_t    i_port_clock,
    input nes_port_pkg::port_bits_t    i_data,
    input wire                         i_core_resetn
);

    import nes_port_pkg::*;

    if (check_shift) begin : g_shift
        port_bits_t clk_prev;
        logic [3:0] shifts [nes_port_count];   // falling edges since the last load

        always_ff @(posedge clk) begin
            if (!sys_resetn) begin
                clk_prev <= '0;
                for (int p = 0; p < nes_port_count; p++) shifts[p] <= '0;
            end else begin
                clk_prev <= i_port_clock;
                for (int p = 0; p < nes_port_count; p++) begin
                    if (i_strobe) begin
                        shifts[p] <= '0;
                    end else if (clk_prev[p] && !i_port_clock[p] && shifts[p] != 4'hf) begin
                        shifts[p] <= shifts[p] + 4'd1;  // saturates
                    end
                end
            end
        end

        for (genvar g = 0; g < nes_port_count; g++) begin : g_port
            a_zero_fill: assert property (@(posedge clk) disable iff (!sys_resetn)
                shifts[g] >= 4'(`PAD_BTN_W) |-> i_data[g] == 1'b0)
                else $error("port %0d data not zero after eight shifts", g);
        end
    end else begin : g_reset
        a_core_reset: assert property (@(posedge clk) !sys_resetn |=> !i_core_resetn)
            else $error("core reset released while system reset is low");
    end

endmodule

bind joypad_shifter pad_properties #(.check_shift(1'b1)) u_props (
    .clk (clk), .sys_resetn (sys_resetn), .i_strobe (i_strobe),
    .i_port_clock (i_clock), .i_data (o_data), .i_core_resetn (1'b1)
);

bind reset_supervisor pad_properties #(.check_shift(1'b0)) u_props (
    .clk (clk), .sys_resetn (sys_resetn), .i_strobe (1'b0),
    .i_port_clock (2'b00), .i_data (2'b00), .i_core_resetn (o_core_resetn)
);

`default_nettype wire

// ==== design/pad_top.sv ====
// pad_top: controller path of the console top level
// two button mappers, joypad shift register, core reset supervisor

`timescale 1ns/1ps
`default_nettype none

module pad_top (
    input  wire                        clk,
    input  wire                        sys_resetn,

    // player 1 sources
    input  pad_pkg::ds_byte_t          i_ds_b0_p1,
    input  pad_pkg::ds_byte_t          i_ds_b1_p1,
    input  pad_pkg::nes_buttons_t      i_usb_btn_p1,
    input  wire                        i_usb_x_p1,
    input  wire                        i_usb_y_p1,
    input  pad_pkg::nes_buttons_t      i_serial_pad_p1,

    // player 2 sources
    input  pad_pkg::ds_byte_t          i_ds_b0_p2,
    input  pad_pkg::ds_byte_t          i_ds_b1_p2,
    input  pad_pkg::nes_buttons_t      i_usb_btn_p2,
    input  wire                        i_usb_x_p2,
    input  wire                        i_usb_y_p2,
    input  pad_pkg::nes_buttons_t      i_serial_pad_p2,

    // NES CPU joypad ports
    input  wire                        i_joypad_strobe,
    input  nes_port_pkg::port_bits_t   i_joypad_clock,
    output nes_port_pkg::port_bits_t   o_joypad_data,

    output wire                        o_core_resetn
);

    import pad_pkg::*;

    nes_buttons_t btn_p1;       // mapped, registered
    nes_buttons_t btn_p2;

    //////////////////////////////
    // button mapping
    //////////////////////////////

    pad_mapper u_map_p1 (
        .clk          (clk),
        .sys_resetn   (sys_resetn),
        .i_ds_b0      (i_ds_b0_p1),
        .i_ds_b1      (i_ds_b1_p1),
        .i_usb_btn    (i_usb_btn_p1),
        .i_serial_pad (i_serial_pad_p1),
        .i_usb_x      (i_usb_x_p1),
        .i_usb_y      (i_usb_y_p1),
        .o_buttons    (btn_p1)
    );

    pad_mapper u_map_p2 (
        .clk          (clk),
        .sys_resetn   (sys_resetn),
        .i_ds_b0      (i_ds_b0_p2),
        .i_ds_b1      (i_ds_b1_p2),
        .i_usb_btn    (i_usb_btn_p2),
        .i_serial_pad (i_serial_pad_p2),
        .i_usb_x      (i_usb_x_p2),
        .i_usb_y      (i_usb_y_p2),
        .o_buttons    (btn_p2)
    );

    //////////////////////////////
    // CPU side and reset
    //////////////////////////////

    joypad_shifter u_shift (
        .clk          (clk),
        .sys_resetn   (sys_resetn),
        .i_buttons_p1 (btn_p1),
        .i_buttons_p2 (btn_p2),
        .i_strobe     (i_joypad_strobe),
        .i_clock      (i_joypad_clock),
        .o_data       (o_joypad_data)
    );

    reset_supervisor u_sup (
        .clk           (clk),
        .sys_resetn    (sys_resetn),
        .i_buttons_p1  (btn_p1),    // hotkey is player 1 only
        .o_core_resetn (o_core_resetn)
    );

endmodule

`default_nettype wire

// ==== design/reset_supervisor.sv ====
// reset_supervisor: core reset generation
// power-up hold counter, then Select+Down hotkey reset from player 1

`timescale 1ns/1ps
`default_nettype none

`include "pad_defines.svh"

module reset_supervisor (
    input  wire                    clk,
    input  wire                    sys_resetn,
    input  pad_pkg::nes_buttons_t  i_buttons_p1,   // registered mapper output
    output logic                   o_core_resetn
);

    import pad_pkg::*;

    localparam int hold_w = $clog2(`PAD_RESET_HOLD + 1);

    logic [hold_w-1:0] hold_cnt;
    logic              hotkey;

    // Select + Down, the 8BitDo Home combination
    assign hotkey = i_buttons_p1[btn_select] & i_buttons_p1[btn_down];

    //////////////////////////////
    // hold counter
    //////////////////////////////

    // counts down to zero, output rises on the edge after that
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            hold_cnt      <= hold_w'(`PAD_RESET_HOLD - 1);
            o_core_resetn <= 1'b0;
        end else if (hold_cnt != '0) begin
            hold_cnt      <= hold_cnt - 1'b1;
            o_core_resetn <= 1'b0;          // still holding after power-up
        end else begin
            o_core_resetn <= ~hotkey;
        end
    end

endmodule

`default_nettype wire

// ==== design/joypad_shifter.sv ====
// joypad_shifter: CPU-side serial joypad ports
// strobe snapshot of both players, falling-edge shift-out per port

`timescale 1ns/1ps
`default_nettype none

`include "pad_defines.svh"

module joypad_shifter (
    input  wire                        clk,
    input  wire                        sys_resetn,
    input  pad_pkg::nes_buttons_t      i_buttons_p1,
    input  pad_pkg::nes_buttons_t      i_buttons_p2,
    input  wire                        i_strobe,        // level, reload while high
    input  nes_port_pkg::port_bits_t   i_clock,         // one serial clock per port
    output nes_port_pkg::port_bits_t   o_data
);

    import pad_pkg::*;
    import nes_port_pkg::*;

    nes_buttons_t [nes_port_count-1:0] load_val;    // snapshot source per port
    nes_buttons_t [nes_port_count-1:0] shift_q;     // bit 0 is on the data line
    port_bits_t                        clk_prev;

    assign load_val[port_p1] = i_buttons_p1;
    assign load_val[port_p2] = i_buttons_p2;

    //////////////////////////////
    // load and shift
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            shift_q  <= '0;
            clk_prev <= '0;
        end else begin
            clk_prev <= i_clock;
            for (int p = 0; p < nes_port_count; p++) begin
                if (i_strobe) begin
                    shift_q[p] <= load_val[p];      // strobe wins over a clock edge
                end else if (clk_prev[p] && !i_clock[p]) begin
                    // next button moves down, zeros fill from the top
                    shift_q[p] <= {1'b0, shift_q[p][`PAD_BTN_W-1:1]};
                end
            end
        end
    end

    // serial data lines
    always_comb begin
        for (int p = 0; p < nes_port_count; p++) begin
            o_data[p] = shift_q[p][0];
        end
    end

endmodule

`default_nettype wire

// ==== design/pad_mapper.sv ====
// pad_mapper: one player's controller sources merged into an NES button byte
// DualShock reorder and invert, USB and serial pad OR merge,
// square and triangle autofire generators

`timescale 1ns/1ps
`default_nettype none

`include "pad_defines.svh"

module pad_mapper (
    input  wire                    clk,
    input  wire                    sys_resetn,
    input  pad_pkg::ds_byte_t      i_ds_b0,         // active low
    input  pad_pkg::ds_byte_t      i_ds_b1,         // active low
    input  pad_pkg::nes_buttons_t  i_usb_btn,
    input  pad_pkg::nes_buttons_t  i_serial_pad,
    input  wire                    i_usb_x,
    input  wire                    i_usb_y,
    output pad_pkg::nes_buttons_t  o_buttons
);

    import pad_pkg::*;

    localparam int af_square   = 0;     // drives B
    localparam int af_triangle = 1;     // drives A
    localparam int af_chans    = 2;
    localparam int af_cnt_w    = ($clog2(`PAD_AUTOFIRE_HALF) > 0) ?
                                 $clog2(`PAD_AUTOFIRE_HALF) : 1;

    ds_byte_t      ds0;                 // DualShock bytes, active high
    ds_byte_t      ds1;
    nes_buttons_t  ds_map;
    nes_buttons_t  merged;

    logic [af_chans-1:0] af_hold;
    logic [af_chans-1:0] af_out;

    assign ds0 = ~i_ds_b0;
    assign ds1 = ~i_ds_b1;

    //////////////////////////////
    // autofire
    //////////////////////////////

    assign af_hold[af_square]   = ds1[ds1_square] | i_usb_y;
    assign af_hold[af_triangle] = ds1[ds1_triangle] | i_usb_x;

    for (genvar g = 0; g < af_chans; g++) begin : g_af
        logic [af_cnt_w-1:0] cnt;
        logic                phase;     // 0 = high half, 1 = low half

        always_ff @(posedge clk) begin
            if (!sys_resetn || !af_hold[g]) begin
                cnt   <= '0;            // restart phase on release
                phase <= 1'b0;
            end else if (cnt == af_cnt_w'(`PAD_AUTOFIRE_HALF - 1)) begin
                cnt   <= '0;
                phase <= ~phase;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end

        // high from the first held cycle, so the output register sees it at once
        assign af_out[g] = af_hold[g] & ~phase;
    end

    //////////////////////////////
    // mapping and merge
    //////////////////////////////

    always_comb begin
        ds_map             = '0;
        ds_map[btn_right]  = ds0[ds0_right];
        ds_map[btn_left]   = ds0[ds0_left];
        ds_map[btn_down]   = ds0[ds0_down];
        ds_map[btn_up]     = ds0[ds0_up];
        ds_map[btn_start]  = ds0[ds0_start];
        ds_map[btn_select] = ds0[ds0_select];
        ds_map[btn_b]      = ds1[ds1_cross] | af_out[af_square];
        ds_map[btn_a]      = ds1[ds1_circle] | af_out[af_triangle];
    end

    // any source can press any button
    assign merged = ds_map | i_usb_btn | i_serial_pad;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            o_buttons <= '0;
        end else begin
            o_buttons <= merged;
        end
    end

endmodule

`default_nettype wire

// ==== design/nes_port_pkg.sv ====
// NES-port-side types
// port count, per-port bit vector for joypad clocks and data lines

`default_nettype none

package nes_port_pkg;

    // two controller ports on the CPU side
    localparam int nes_port_count = 2;

    // port indices into a port_bits_t
    localparam int port_p1 = 0;
    localparam int port_p2 = 1;

    // one bit per port, used for the serial clocks and the data lines
    typedef logic [nes_port_count-1:0] port_bits_t;

endpackage

`default_nettype wire

// ==== design/pad_pkg.sv ====
// controller-side types
// NES button byte, DualShock byte, NES bit positions, DualShock bit positions

`default_nettype none

`include "pad_defines.svh"

package pad_pkg;

    typedef logic [`PAD_BTN_W-1:0] nes_buttons_t;   // bit 7..0 = R L D U START SELECT B A
    typedef logic [`PAD_DS_W-1:0] ds_byte_t;        // active low, as received

    // NES button byte bit positions
    typedef enum logic [2:0] {
        btn_a      = 3'd0,
        btn_b      = 3'd1,
        btn_select = 3'd2,
        btn_start  = 3'd3,
        btn_up     = 3'd4,
        btn_down   = 3'd5,
        btn_left   = 3'd6,
        btn_right  = 3'd7
    } pad_btn_e;

    // DualShock byte 0: L D R U St R3 L3 Se (msb first)
    localparam int unsigned ds0_select = 0;
    localparam int unsigned ds0_start  = 3;
    localparam int unsigned ds0_up     = 4;
    localparam int unsigned ds0_right  = 5;
    localparam int unsigned ds0_down   = 6;
    localparam int unsigned ds0_left   = 7;

    // DualShock byte 1: square cross circle triangle R1 L1 R2 L2
    localparam int unsigned ds1_triangle = 4;
    localparam int unsigned ds1_circle   = 5;   // NES A
    localparam int unsigned ds1_cross    = 6;   // NES B
    localparam int unsigned ds1_square   = 7;

endpackage

`default_nettype wire

// ==== design/pad_defines.svh ====
// shared width and timing macros for the controller path
// button and dualshock byte widths, autofire rate, core reset hold

`ifndef PAD_DEFINES_SVH
`define PAD_DEFINES_SVH

//////////////////////////////
// widths
//////////////////////////////

`define PAD_BTN_W 8             // NES button byte, R L D U START SELECT B A
`define PAD_DS_W 8              // one DualShock RX byte

//////////////////////////////
// timing
//////////////////////////////

// cycles high, then cycles low, while an autofire button is held
// kept short so a simulation run stays small
`define PAD_AUTOFIRE_HALF 8

// cycles the core stays in reset once sys_resetn is released
`define PAD_RESET_HOLD 255

`endif
